//--- dv/bank_model.sv
`timescale 1ns/1ps

module bank_model import mem_types_pkg::*; (
	input  logic       CLK,
	input  bank_addr_t addr,
	input  word_t      din,
	input  byte_mask_t mask,	// bit 1 high byte
	input  logic       wr,
	output word_t      dout	// valid one cycle after addr
);

	word_t mem [2**14];	// 16K words

	always_ff @(posedge CLK)
	begin
		if (wr && mask[1])
			mem[addr][15:8] <= din[15:8];	// high byte lane
		if (wr && mask[0])
			mem[addr][7:0] <= din[7:0];	// low byte lane
		dout <= mem[addr];	// old data on a same cycle write
	end

endmodule

//--- dv/tb_memory_arbiter.sv
`timescale 1ns/1ps

module tb_memory_arbiter import mem_types_pkg::*;;

	localparam int HOLD_LIMIT  = 4;	// short grants so the limit shows up
	localparam int MAX_ENTRIES = 40;
	localparam int WHO_CPU     = 0;
	localparam int WHO_FL      = 1;
	localparam int WHO_SP      = 2;
	localparam int WHO_BG      = 3;

	logic CLK = 1'b0;
	logic rst;
	logic cpu_valid, cpu_wr, cpu_ready, cpu_rvalid;
	cpu_addr_t cpu_addr;
	word_t cpu_wdata, cpu_rdata;
	byte_mask_t cpu_mask;
	logic fl_valid, fl_ready;
	periph_addr_t fl_addr;
	word_t fl_wdata;
	logic sp_valid, sp_ready, sp_rvalid;
	periph_addr_t sp_addr;
	word_t sp_rdata;
	logic bg_valid, bg_ready, bg_rvalid;
	periph_addr_t bg_addr;
	word_t bg_rdata;
	bank_addr_t b1_addr, b2_addr, b3_addr, b4_addr;
	word_t b1_din, b2_din, b3_din, b4_din;
	word_t b1_dout, b2_dout, b3_dout, b4_dout;
	byte_mask_t b1_mask, b2_mask, b3_mask, b4_mask;
	logic b1_wr, b2_wr, b3_wr, b4_wr;

	// stimulus table with one column per array
	string        t_name  [MAX_ENTRIES];
	int           t_step  [MAX_ENTRIES];	// same step runs in parallel
	int           t_who   [MAX_ENTRIES];
	periph_addr_t t_addr  [MAX_ENTRIES];	// bank in [15:14]
	word_t        t_wdata [MAX_ENTRIES];
	byte_mask_t   t_mask  [MAX_ENTRIES];
	logic         t_wr    [MAX_ENTRIES];
	int           t_delay [MAX_ENTRIES];	// cycles before valid rises
	int           t_waits [MAX_ENTRIES];	// expected cycles with ready low
	int           t_beats [MAX_ENTRIES];	// flash burst length
	int           n_entries = 0;

	word_t  ref_mem [65536];	// expected contents by global address
	integer seed = 32'hc047833e;
	int     n_tests = 0;
	int     n_failed = 0;
	int     n_errors = 0;
	int     cycles = 0;
	int     cycle_limit = 0;

	always #50 CLK = ~CLK;	// 100 ns period

	memory_arbiter #(.HOLD_LIMIT(HOLD_LIMIT)) memory_arbiter_i (.*);

	bank_model bank1_i (.CLK, .addr(b1_addr), .din(b1_din), .mask(b1_mask), .wr(b1_wr),
		.dout(b1_dout));
	bank_model bank2_i (.CLK, .addr(b2_addr), .din(b2_din), .mask(b2_mask), .wr(b2_wr),
		.dout(b2_dout));
	bank_model bank3_i (.CLK, .addr(b3_addr), .din(b3_din), .mask(b3_mask), .wr(b3_wr),
		.dout(b3_dout));
	bank_model bank4_i (.CLK, .addr(b4_addr), .din(b4_din), .mask(b4_mask), .wr(b4_wr),
		.dout(b4_dout));

	always @(posedge CLK)
	begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("timeout: run still busy after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic word_t merge_bytes(input word_t old, input word_t nw, input byte_mask_t m);
		word_t r;
		r = old;
		if (m[1])
			r[15:8] = nw[15:8];	// high byte replaced
		if (m[0])
			r[7:0] = nw[7:0];
		return r;
	endfunction

	task automatic check_word(input string what, input word_t exp, input word_t act,
		inout int bad);
		if (act !== exp)
		begin
			$display("ERR %s: expected %h, got %h", what, exp, act);
			bad++;
			n_errors++;
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act,
		inout int bad);
		if (act !== exp)
		begin
			$display("ERR %s: expected %b, got %b", what, exp, act);
			bad++;
			n_errors++;
		end
	endtask

	task automatic check_count(input string what, input int exp, input int act, inout int bad);
		if (act != exp)
		begin
			$display("ERR %s: expected %0d, got %0d", what, exp, act);
			bad++;
			n_errors++;
		end
	endtask

	task automatic report_result(input string name, input int bad);
		n_tests++;
		if (bad == 0)
			$display("%-14s ok", name);
		else
		begin
			n_failed++;
			$display("%-14s failed, %0d bad checks", name, bad);
		end
	endtask

	task automatic add_entry(input string name, input int step, input int who,
		input periph_addr_t addr, input word_t wdata, input byte_mask_t mask, input logic wr,
		input int delay, input int waits, input int beats);
		t_name[n_entries]  = name;
		t_step[n_entries]  = step;
		t_who[n_entries]   = who;
		t_addr[n_entries]  = addr;
		t_wdata[n_entries] = wdata;
		t_mask[n_entries]  = mask;
		t_wr[n_entries]    = wr;
		t_delay[n_entries] = delay;
		t_waits[n_entries] = waits;
		t_beats[n_entries] = beats;
		n_entries++;
	endtask

	task automatic build_table();
		// name            step who      addr      wdata     mask   wr    dly wait beats
		add_entry("cpu_b1_full",  1, WHO_CPU, 16'h0010, 16'h1234, 2'b11, 1'b1, 0, 0, 1);
		add_entry("cpu_b1_lo",    2, WHO_CPU, 16'h0010, 16'habcd, 2'b01, 1'b1, 0, 0, 1);
		add_entry("cpu_b1_rd1",   3, WHO_CPU, 16'h0010, 16'h0000, 2'b00, 1'b0, 0, 0, 1);
		add_entry("cpu_b1_hi",    4, WHO_CPU, 16'h0010, 16'h5678, 2'b10, 1'b1, 0, 0, 1);
		add_entry("cpu_b1_none",  5, WHO_CPU, 16'h0010, 16'hffff, 2'b00, 1'b1, 0, 0, 1);
		add_entry("cpu_b1_rd2",   6, WHO_CPU, 16'h0010, 16'h0000, 2'b00, 1'b0, 0, 0, 1);
		add_entry("cpu_b2_full",  7, WHO_CPU, 16'h4020, 16'h9abc, 2'b11, 1'b1, 0, 0, 1);
		add_entry("cpu_b2_hi",    8, WHO_CPU, 16'h4020, 16'h3cff, 2'b10, 1'b1, 0, 0, 1);
		add_entry("cpu_b2_rd1",   9, WHO_CPU, 16'h4020, 16'h0000, 2'b00, 1'b0, 0, 0, 1);
		add_entry("cpu_b2_lo",   10, WHO_CPU, 16'h4020, 16'h00a5, 2'b01, 1'b1, 0, 0, 1);
		add_entry("cpu_b2_none", 11, WHO_CPU, 16'h4020, 16'h0000, 2'b00, 1'b1, 0, 0, 1);
		add_entry("cpu_b2_rd2",  12, WHO_CPU, 16'h4020, 16'h0000, 2'b00, 1'b0, 0, 0, 1);
		// flash words come from the seeded generator
		add_entry("fl_fill_b1",  13, WHO_FL,  16'h0040, 16'h0000, 2'b11, 1'b1, 0, 1, 3);
		add_entry("fl_fill_b2",  14, WHO_FL,  16'h4040, 16'h0000, 2'b11, 1'b1, 0, 1, 3);
		add_entry("fl_fill_b3",  15, WHO_FL,  16'h8040, 16'h0000, 2'b11, 1'b1, 0, 1, 3);
		add_entry("fl_fill_b4",  16, WHO_FL,  16'hc040, 16'h0000, 2'b11, 1'b1, 0, 1, 3);
		add_entry("cpu_rd_b1",   17, WHO_CPU, 16'h0041, 16'h0000, 2'b00, 1'b0, 0, 0, 1);
		add_entry("cpu_rd_b2",   18, WHO_CPU, 16'h4042, 16'h0000, 2'b00, 1'b0, 0, 0, 1);
		add_entry("sp_rd_b2",    19, WHO_SP,  16'h4040, 16'h0000, 2'b00, 1'b0, 0, 1, 1);
		add_entry("sp_rd_b3",    20, WHO_SP,  16'h8042, 16'h0000, 2'b00, 1'b0, 0, 1, 1);
		add_entry("bg_rd_b2",    21, WHO_BG,  16'h4041, 16'h0000, 2'b00, 1'b0, 0, 1, 1);
		add_entry("bg_rd_b4",    22, WHO_BG,  16'hc040, 16'h0000, 2'b00, 1'b0, 0, 1, 1);
		// cpu arrives while flash owns bank 2
		add_entry("cont_fl",     23, WHO_FL,  16'h4080, 16'h0000, 2'b11, 1'b1, 0, 1, 1);
		add_entry("cont_cpu",    23, WHO_CPU, 16'h4080, 16'h0000, 2'b00, 1'b0, 1, 2, 1);
		// long flash burst with the cpu slipping in at the expiry gap
		add_entry("hold_fl",     24, WHO_FL,  16'h0100, 16'h0000, 2'b11, 1'b1, 0, 1, 10);
		add_entry("hold_cpu",    24, WHO_CPU, 16'h0200, 16'h0f0f, 2'b11, 1'b1, 2, 3, 1);
		add_entry("hold_rd",     25, WHO_CPU, 16'h0109, 16'h0000, 2'b00, 1'b0, 0, 0, 1);
		add_entry("par_cpu",     26, WHO_CPU, 16'h0200, 16'h0000, 2'b00, 1'b0, 0, 0, 1);
		add_entry("par_sp",      26, WHO_SP,  16'h8040, 16'h0000, 2'b00, 1'b0, 0, 1, 1);
		add_entry("par_bg",      26, WHO_BG,  16'hc041, 16'h0000, 2'b00, 1'b0, 0, 1, 1);
	endtask

	task automatic run_cpu(input int i);
		int    waits = 0;
		int    bad = 0;
		word_t exp;
		@(posedge CLK);
		repeat (t_delay[i]) @(posedge CLK);
		cpu_valid <= 1'b1;
		cpu_addr  <= cpu_addr_t'(t_addr[i]);	// banks 1-2 only
		cpu_wdata <= t_wdata[i];
		cpu_wr    <= t_wr[i];
		cpu_mask  <= t_mask[i];
		@(negedge CLK);
		while (!cpu_ready)
		begin
			waits++;
			@(negedge CLK);
		end
		@(posedge CLK);	// accepting edge
		cpu_valid <= 1'b0;
		if (t_wr[i])
			ref_mem[t_addr[i]] = merge_bytes(ref_mem[t_addr[i]], t_wdata[i], t_mask[i]);
		exp = ref_mem[t_addr[i]];
		@(negedge CLK);
		check_flag({t_name[i], " rvalid"}, !t_wr[i], cpu_rvalid, bad);	// loads only
		if (!t_wr[i])
			check_word({t_name[i], " rdata"}, exp, cpu_rdata, bad);
		check_count({t_name[i], " waits"}, t_waits[i], waits, bad);
		report_result(t_name[i], bad);
	endtask

	task automatic run_flash(input int i);
		periph_addr_t a = t_addr[i];
		word_t        d;
		int           left = t_beats[i];
		int           run = 0;	// consecutive ready cycles
		int           waits = 0;
		int           bad = 0;
		logic         started = 1'b0;
		d = word_t'($random(seed));
		@(posedge CLK);
		repeat (t_delay[i]) @(posedge CLK);
		fl_valid <= 1'b1;
		fl_addr  <= a;
		fl_wdata <= d;
		while (left > 0)
		begin
			@(negedge CLK);
			if (fl_ready)
			begin
				run++;
				started = 1'b1;
				if (run > HOLD_LIMIT)
				begin
					$display("%s: flash kept the bank %0d cycles, over the limit of %0d",
						t_name[i], run, HOLD_LIMIT);
					bad++;
					n_errors++;
				end
				@(posedge CLK);	// beat accepted
				ref_mem[a] = d;
				left--;
				a++;
				d = word_t'($random(seed));
				if (left > 0)
				begin
					fl_addr  <= a;
					fl_wdata <= d;
				end
				else
					fl_valid <= 1'b0;
			end
			else if (!started)
				waits++;
			else if (run > 0)
			begin
				// grant ended with valid still high, so it must have expired
				check_count({t_name[i], " grant length"}, HOLD_LIMIT, run, bad);
				if (a[15:14] == {1'b0, cpu_addr[14]})
					check_flag({t_name[i], " cpu_ready in gap"}, 1'b1, cpu_ready, bad);
				run = 0;
			end
		end
		check_count({t_name[i], " waits"}, t_waits[i], waits, bad);
		report_result(t_name[i], bad);
	endtask

	task automatic run_periph_read(input int i, input logic is_bg);
		int    waits = 0;
		int    bad = 0;
		word_t exp;
		@(posedge CLK);
		repeat (t_delay[i]) @(posedge CLK);
		if (is_bg)
		begin
			bg_valid <= 1'b1;
			bg_addr  <= t_addr[i];
		end
		else
		begin
			sp_valid <= 1'b1;
			sp_addr  <= t_addr[i];
		end
		@(negedge CLK);
		while (!(is_bg ? bg_ready : sp_ready))
		begin
			waits++;	// takeover pending
			@(negedge CLK);
		end
		@(posedge CLK);
		if (is_bg)
			bg_valid <= 1'b0;
		else
			sp_valid <= 1'b0;
		exp = ref_mem[t_addr[i]];
		@(negedge CLK);
		check_flag({t_name[i], " rvalid"}, 1'b1, is_bg ? bg_rvalid : sp_rvalid, bad);
		check_word({t_name[i], " rdata"}, exp, is_bg ? bg_rdata : sp_rdata, bad);
		check_count({t_name[i], " waits"}, t_waits[i], waits, bad);
		report_result(t_name[i], bad);
	endtask

	initial
	begin
		int i;
		int step;
		int ci;
		int fi;
		int si;
		int bi;
		int bad;
		rst       <= 1'b1;
		cpu_valid <= 1'b0;
		cpu_addr  <= '0;
		cpu_wdata <= '0;
		cpu_wr    <= 1'b0;
		cpu_mask  <= '0;
		fl_valid  <= 1'b0;
		fl_addr   <= '0;
		fl_wdata  <= '0;
		sp_valid  <= 1'b0;
		sp_addr   <= '0;
		bg_valid  <= 1'b0;
		bg_addr   <= '0;
		build_table();
		cycle_limit = n_entries * HOLD_LIMIT * 4 + 50;	// generous per entry
		repeat (10) @(posedge CLK);
		rst <= 1'b0;
		@(negedge CLK);
		bad = 0;
		check_flag("reset_state fl_ready", 1'b0, fl_ready, bad);
		check_flag("reset_state bg_ready", 1'b0, bg_ready, bad);
		check_flag("reset_state sp_ready", 1'b0, sp_ready, bad);
		check_flag("reset_state cpu_ready", 1'b1, cpu_ready, bad);
		check_flag("reset_state cpu_rvalid", 1'b0, cpu_rvalid, bad);
		check_flag("reset_state bg_rvalid", 1'b0, bg_rvalid, bad);
		check_flag("reset_state sp_rvalid", 1'b0, sp_rvalid, bad);
		check_flag("reset_state bank_wr", 1'b0, b1_wr | b2_wr | b3_wr | b4_wr, bad);
		report_result("reset_state", bad);
		i = 0;
		while (i < n_entries)
		begin
			step = t_step[i];
			ci = -1;
			fi = -1;
			si = -1;
			bi = -1;
			while (i < n_entries && t_step[i] == step)	// gather one step
			begin
				case (t_who[i])
					WHO_CPU: ci = i;
					WHO_FL:  fi = i;
					WHO_SP:  si = i;
					default: bi = i;
				endcase
				i++;
			end
			fork
				if (ci >= 0) run_cpu(ci);
				if (fi >= 0) run_flash(fi);
				if (si >= 0) run_periph_read(si, 1'b0);
				if (bi >= 0) run_periph_read(bi, 1'b1);
			join
		end
		$display("%0d tests, %0d failed, %0d check errors", n_tests, n_failed, n_errors);
		if (n_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- run.sh
#!/bin/sh
# build and run the memory arbiter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
	--top-module tb_memory_arbiter -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "TEST PASSED"; then
	exit 0
fi
exit 1

//--- src/arb_pkg.sv
package arb_pkg;

	localparam int NUM_BANKS = 4;	// banks shared by the requesters

	// who drives a bank this cycle
	typedef enum logic [1:0] {
		OWNER_CPU    = 2'd0,	// default owner
		OWNER_FLASH  = 2'd1,	// write only
		OWNER_BG     = 2'd2,	// read only
		OWNER_SPRITE = 2'd3	// read only
	} owner_e;

	// per bank arbitration state
	typedef enum logic {
		ST_CPU    = 1'b0,	// cpu has the bank
		ST_PERIPH = 1'b1	// peripheral holds the bank
	} arb_state_e;

endpackage

//--- src/bank_arbiter.sv
`timescale 1ns/1ps

module bank_arbiter import arb_pkg::*; #(
	parameter int HOLD_LIMIT = 8	// grant length passed to the timer
) (
	input  logic   CLK,
	input  logic   rst,
	input  logic   req_fl,	// flash wants this bank
	input  logic   req_bg,	// background wants this bank
	input  logic   req_sp,	// sprite wants this bank
	output owner_e owner	// current bank owner
);

	arb_state_e state;
	arb_state_e state_nxt;
	owner_e     owner_nxt;
	logic       owner_req;	// request of the present owner
	logic       expired;	// grant used up

	hold_timer #(
		.HOLD_LIMIT(HOLD_LIMIT)
	) hold_timer_i (
		.CLK     (CLK),
		.rst     (rst),
		.run     (state == ST_PERIPH),	// counts only while held
		.expired (expired)
	);

	// request line of whoever holds the bank
	always_comb
	begin
		case (owner)
			OWNER_FLASH:  owner_req = req_fl;
			OWNER_BG:     owner_req = req_bg;
			OWNER_SPRITE: owner_req = req_sp;
			default:      owner_req = 1'b0;	// cpu never requests
		endcase
	end

	always_comb
	begin
		state_nxt = state;
		owner_nxt = owner;
		case (state)
			ST_CPU:
			begin
				if (req_fl)
				begin
					state_nxt = ST_PERIPH;
					owner_nxt = OWNER_FLASH;	// flash wins
				end
				else if (req_bg)
				begin
					state_nxt = ST_PERIPH;
					owner_nxt = OWNER_BG;	// then background
				end
				else if (req_sp)
				begin
					state_nxt = ST_PERIPH;
					owner_nxt = OWNER_SPRITE;	// sprite last
				end
			end
			ST_PERIPH:
			begin
				if (!owner_req || expired)
				begin
					state_nxt = ST_CPU;	// back to cpu for a cycle at least
					owner_nxt = OWNER_CPU;
				end
			end
			default:
			begin
				state_nxt = ST_CPU;
				owner_nxt = OWNER_CPU;
			end
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			state <= ST_CPU;
			owner <= OWNER_CPU;
		end
		else
		begin
			state <= state_nxt;
			owner <= owner_nxt;
		end
	end

	cpu_owns_idle: assert property (@(posedge CLK) disable iff (rst)
		state == ST_CPU |-> owner == OWNER_CPU);

	// an expired grant always gives the cpu its cycle
	no_direct_regrant: assert property (@(posedge CLK) disable iff (rst)
		expired |=> state == ST_CPU);

endmodule

//--- src/bank_mux.sv
`timescale 1ns/1ps

module bank_mux import mem_types_pkg::*, arb_pkg::*; (
	input  owner_e     owner,	// from this bank's arbiter
	input  logic       cpu_valid,	// cpu request aimed at this bank
	input  logic       cpu_wr,
	input  bank_addr_t cpu_addr,
	input  word_t      cpu_wdata,
	input  byte_mask_t cpu_mask,
	input  logic       fl_valid,	// flash request aimed at this bank
	input  bank_addr_t fl_addr,
	input  bank_addr_t bg_addr,
	input  bank_addr_t sp_addr,
	input  word_t      fl_wdata,
	output bank_addr_t bank_addr,
	output word_t      bank_din,
	output byte_mask_t bank_mask,
	output logic       bank_wr
);

	// address follows the owner
	always_comb
	begin
		case (owner)
			OWNER_FLASH:  bank_addr = fl_addr;
			OWNER_BG:     bank_addr = bg_addr;
			OWNER_SPRITE: bank_addr = sp_addr;
			default:      bank_addr = cpu_addr;
		endcase
	end

	// only cpu and flash ever write
	assign bank_din = (owner == OWNER_FLASH) ? fl_wdata : cpu_wdata;

	// peripherals always use full words
	assign bank_mask = (owner == OWNER_CPU) ? cpu_mask : byte_mask_t'(2'b11);

	always_comb
	begin
		case (owner)
			OWNER_CPU:   bank_wr = cpu_valid && cpu_wr;	// cpu store
			OWNER_FLASH: bank_wr = fl_valid;	// every flash beat writes
			default:     bank_wr = 1'b0;	// sprite and bg only read
		endcase
	end

endmodule

//--- src/hold_timer.sv
`timescale 1ns/1ps

module hold_timer #(
	parameter int HOLD_LIMIT = 8	// max cycles of one grant
) (
	input  logic CLK,
	input  logic rst,
	input  logic run,	// bank held by a peripheral
	output logic expired	// last cycle of the grant
);

	localparam int CW = $clog2(HOLD_LIMIT + 1);	// fits 0..HOLD_LIMIT

	logic [CW-1:0] count;	// cycles held so far

	// final grant cycle when count hits limit-1
	assign expired = run && (count == CW'(HOLD_LIMIT - 1));

	always_ff @(posedge CLK)
	begin
		if (rst)
			count <= '0;
		else if (!run || expired)
			count <= '0;	// grant dropped or used up
		else
			count <= count + 1'b1;	// one more held cycle
	end

	// count stays within the grant length
	count_in_range: assert property (@(posedge CLK) disable iff (rst)
		count <= CW'(HOLD_LIMIT));

endmodule

//--- src/mem_types_pkg.sv
package mem_types_pkg;

	// data path
	typedef logic [15:0] word_t;		// one memory word

	// addressing
	typedef logic [13:0] bank_addr_t;	// word address inside one 16K bank
	typedef logic [14:0] cpu_addr_t;	// msb picks bank 1 or bank 2
	typedef logic [15:0] periph_addr_t;	// top two bits pick the bank

	// byte lanes
	typedef logic [1:0] byte_mask_t;	// bit 1 high byte, bit 0 low byte

	// bank numbering
	typedef logic [1:0] bank_idx_t;		// bank 1..4 as 0..3

endpackage

//--- src/memory_arbiter.sv
`timescale 1ns/1ps

module memory_arbiter import mem_types_pkg::*, arb_pkg::*; #(
	parameter int HOLD_LIMIT = 8	// max peripheral grant in cycles
) (
	input  logic         CLK,
	input  logic         rst,
	input  logic         cpu_valid,
	input  cpu_addr_t    cpu_addr,
	input  word_t        cpu_wdata,
	input  logic         cpu_wr,
	input  byte_mask_t   cpu_mask,
	output logic         cpu_ready,
	output word_t        cpu_rdata,
	output logic         cpu_rvalid,
	input  logic         fl_valid,
	input  periph_addr_t fl_addr,
	input  word_t        fl_wdata,
	output logic         fl_ready,
	input  logic         sp_valid,
	input  periph_addr_t sp_addr,
	output logic         sp_ready,
	output word_t        sp_rdata,
	output logic         sp_rvalid,
	input  logic         bg_valid,
	input  periph_addr_t bg_addr,
	output logic         bg_ready,
	output word_t        bg_rdata,
	output logic         bg_rvalid,
	output bank_addr_t   b1_addr,
	output word_t        b1_din,
	output byte_mask_t   b1_mask,
	output logic         b1_wr,
	input  word_t        b1_dout,
	output bank_addr_t   b2_addr,
	output word_t        b2_din,
	output byte_mask_t   b2_mask,
	output logic         b2_wr,
	input  word_t        b2_dout,
	output bank_addr_t   b3_addr,
	output word_t        b3_din,
	output byte_mask_t   b3_mask,
	output logic         b3_wr,
	input  word_t        b3_dout,
	output bank_addr_t   b4_addr,
	output word_t        b4_din,
	output byte_mask_t   b4_mask,
	output logic         b4_wr,
	input  word_t        b4_dout
);

	owner_e               own [NUM_BANKS];	// per bank owner
	logic [NUM_BANKS-1:0] cpu_req;
	logic [NUM_BANKS-1:0] req_fl;
	logic [NUM_BANKS-1:0] req_bg;
	logic [NUM_BANKS-1:0] req_sp;
	bank_addr_t           cpu_baddr;
	byte_mask_t           cpu_bmask;

	port_router port_router_i (
		.CLK(CLK), .rst(rst),
		.cpu_valid(cpu_valid), .cpu_addr(cpu_addr), .cpu_wr(cpu_wr), .cpu_mask(cpu_mask),
		.fl_valid(fl_valid), .fl_addr(fl_addr),
		.bg_valid(bg_valid), .bg_addr(bg_addr), .sp_valid(sp_valid), .sp_addr(sp_addr),
		.own1(own[0]), .own2(own[1]), .own3(own[2]), .own4(own[3]),
		.b1_dout(b1_dout), .b2_dout(b2_dout), .b3_dout(b3_dout), .b4_dout(b4_dout),
		.cpu_req(cpu_req), .req_fl(req_fl), .req_bg(req_bg), .req_sp(req_sp),
		.cpu_baddr(cpu_baddr), .cpu_bmask(cpu_bmask),
		.cpu_ready(cpu_ready), .fl_ready(fl_ready), .bg_ready(bg_ready), .sp_ready(sp_ready),
		.cpu_rdata(cpu_rdata), .bg_rdata(bg_rdata), .sp_rdata(sp_rdata),
		.cpu_rvalid(cpu_rvalid), .bg_rvalid(bg_rvalid), .sp_rvalid(sp_rvalid)
	);

	// one arbiter per bank
	for (genvar i = 0; i < NUM_BANKS; i++)
	begin : g_bank_arb
		bank_arbiter #(.HOLD_LIMIT(HOLD_LIMIT)) bank_arbiter_i (
			.CLK(CLK), .rst(rst),
			.req_fl(req_fl[i]), .req_bg(req_bg[i]), .req_sp(req_sp[i]),
			.owner(own[i])
		);
	end

	bank_mux bank_mux1_i (
		.owner(own[0]), .cpu_valid(cpu_req[0]), .cpu_wr(cpu_wr),
		.cpu_addr(cpu_baddr), .cpu_wdata(cpu_wdata), .cpu_mask(cpu_bmask),
		.fl_valid(req_fl[0]), .fl_addr(fl_addr[13:0]), .fl_wdata(fl_wdata),
		.bg_addr(bg_addr[13:0]), .sp_addr(sp_addr[13:0]),
		.bank_addr(b1_addr), .bank_din(b1_din), .bank_mask(b1_mask), .bank_wr(b1_wr)
	);

	bank_mux bank_mux2_i (
		.owner(own[1]), .cpu_valid(cpu_req[1]), .cpu_wr(cpu_wr),
		.cpu_addr(cpu_baddr), .cpu_wdata(cpu_wdata), .cpu_mask(cpu_bmask),
		.fl_valid(req_fl[1]), .fl_addr(fl_addr[13:0]), .fl_wdata(fl_wdata),
		.bg_addr(bg_addr[13:0]), .sp_addr(sp_addr[13:0]),
		.bank_addr(b2_addr), .bank_din(b2_din), .bank_mask(b2_mask), .bank_wr(b2_wr)
	);

	bank_mux bank_mux3_i (
		.owner(own[2]), .cpu_valid(cpu_req[2]), .cpu_wr(cpu_wr),
		.cpu_addr(cpu_baddr), .cpu_wdata(cpu_wdata), .cpu_mask(cpu_bmask),
		.fl_valid(req_fl[2]), .fl_addr(fl_addr[13:0]), .fl_wdata(fl_wdata),
		.bg_addr(bg_addr[13:0]), .sp_addr(sp_addr[13:0]),
		.bank_addr(b3_addr), .bank_din(b3_din), .bank_mask(b3_mask), .bank_wr(b3_wr)
	);

	bank_mux bank_mux4_i (
		.owner(own[3]), .cpu_valid(cpu_req[3]), .cpu_wr(cpu_wr),
		.cpu_addr(cpu_baddr), .cpu_wdata(cpu_wdata), .cpu_mask(cpu_bmask),
		.fl_valid(req_fl[3]), .fl_addr(fl_addr[13:0]), .fl_wdata(fl_wdata),
		.bg_addr(bg_addr[13:0]), .sp_addr(sp_addr[13:0]),
		.bank_addr(b4_addr), .bank_din(b4_din), .bank_mask(b4_mask), .bank_wr(b4_wr)
	);

endmodule

//--- src/port_router.sv
`timescale 1ns/1ps

module port_router import mem_types_pkg::*, arb_pkg::*; (
	input  logic                 CLK,
	input  logic                 rst,
	input  logic                 cpu_valid,
	input  cpu_addr_t            cpu_addr,
	input  logic                 cpu_wr,
	input  byte_mask_t           cpu_mask,
	input  logic                 fl_valid,
	input  periph_addr_t         fl_addr,
	input  logic                 bg_valid,
	input  periph_addr_t         bg_addr,
	input  logic                 sp_valid,
	input  periph_addr_t         sp_addr,
	input  owner_e               own1,
	input  owner_e               own2,
	input  owner_e               own3,
	input  owner_e               own4,
	input  word_t                b1_dout,
	input  word_t                b2_dout,
	input  word_t                b3_dout,
	input  word_t                b4_dout,
	output logic [NUM_BANKS-1:0] cpu_req,	// one hot cpu target
	output logic [NUM_BANKS-1:0] req_fl,	// one hot flash target
	output logic [NUM_BANKS-1:0] req_bg,	// one hot background target
	output logic [NUM_BANKS-1:0] req_sp,	// one hot sprite target
	output bank_addr_t           cpu_baddr,	// cpu address inside the bank
	output byte_mask_t           cpu_bmask,	// zero on reads
	output logic                 cpu_ready,
	output logic                 fl_ready,
	output logic                 bg_ready,
	output logic                 sp_ready,
	output word_t                cpu_rdata,
	output word_t                bg_rdata,
	output word_t                sp_rdata,
	output logic                 cpu_rvalid,
	output logic                 bg_rvalid,
	output logic                 sp_rvalid
);

	owner_e    own [NUM_BANKS];	// owners indexed by bank
	word_t     dout [NUM_BANKS];	// read data indexed by bank
	bank_idx_t cpu_bank;
	bank_idx_t fl_bank;
	bank_idx_t bg_bank;
	bank_idx_t sp_bank;
	logic      bg_ok;	// bg address hits bank 2 or 4
	logic      sp_ok;	// sprite address hits bank 2 or 3
	bank_idx_t cpu_src;	// bank of the cpu read in flight
	bank_idx_t bg_src;
	bank_idx_t sp_src;

	assign own[0]  = own1;
	assign own[1]  = own2;
	assign own[2]  = own3;
	assign own[3]  = own4;
	assign dout[0] = b1_dout;
	assign dout[1] = b2_dout;
	assign dout[2] = b3_dout;
	assign dout[3] = b4_dout;

	// bank decode
	assign cpu_bank = {1'b0, cpu_addr[14]};	// cpu sees banks 1 and 2 only
	assign fl_bank  = fl_addr[15:14];
	assign bg_bank  = bg_addr[15:14];
	assign sp_bank  = sp_addr[15:14];
	assign bg_ok    = (bg_bank == 2'd1) || (bg_bank == 2'd3);
	assign sp_ok    = (sp_bank == 2'd1) || (sp_bank == 2'd2);

	assign cpu_req = cpu_valid ? (NUM_BANKS'(1) << cpu_bank) : '0;
	assign req_fl  = fl_valid ? (NUM_BANKS'(1) << fl_bank) : '0;
	assign req_bg  = (bg_valid && bg_ok) ? (NUM_BANKS'(1) << bg_bank) : '0;	// stray bg dropped
	assign req_sp  = (sp_valid && sp_ok) ? (NUM_BANKS'(1) << sp_bank) : '0;

	assign cpu_baddr = cpu_addr[13:0];
	assign cpu_bmask = cpu_wr ? cpu_mask : '0;

	// ready straight from the target bank's owner
	assign cpu_ready = (own[cpu_bank] == OWNER_CPU);
	assign fl_ready  = (own[fl_bank] == OWNER_FLASH);
	assign bg_ready  = bg_ok && (own[bg_bank] == OWNER_BG);
	assign sp_ready  = sp_ok && (own[sp_bank] == OWNER_SPRITE);

	// one cycle read return
	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			cpu_rvalid <= 1'b0;
			bg_rvalid  <= 1'b0;
			sp_rvalid  <= 1'b0;
		end
		else
		begin
			cpu_rvalid <= cpu_valid && cpu_ready && !cpu_wr;	// accepted cpu load
			bg_rvalid  <= bg_valid && bg_ready;
			sp_rvalid  <= sp_valid && sp_ready;
		end
	end

	always_ff @(posedge CLK)
	begin
		cpu_src <= cpu_bank;	// remember where the data comes from
		bg_src  <= bg_bank;
		sp_src  <= sp_bank;
	end

	assign cpu_rdata = dout[cpu_src];
	assign bg_rdata  = dout[bg_src];
	assign sp_rdata  = dout[sp_src];

	// sprite only on banks 2-3, background only on banks 2 and 4
	periph_bank_map: assert property (@(posedge CLK) disable iff (rst)
		!req_sp[0] && !req_sp[3] && !req_bg[0] && !req_bg[2]);

endmodule

//--- tb.f
src/mem_types_pkg.sv
src/arb_pkg.sv
src/hold_timer.sv
src/bank_arbiter.sv
src/bank_mux.sv
src/port_router.sv
src/memory_arbiter.sv
dv/bank_model.sv
dv/tb_memory_arbiter.sv
